/* tb/csr_trace.txt */
# kind f0 f1 f2 f3, hex. W: op addr data killed  R: addr killed expect -  E: code pc instr -
# M: return  P: priv  N: cycles killed hold  I: irq pc jump target.  Ops 1 write 2 set 3 clear
# Masked access
R 301 0 40101100 0
R f11 0 00000000 0
W 1 340 ffffffff 0
R 340 0 ffffffff 0
W 1 305 ffffffff 0
R 305 0 fffffffc 0
W 1 304 ffffffff 0
R 304 0 00000888 0
W 3 304 fffff800 0
R 304 0 00000088 0
W 2 304 00000f0f 0
R 304 0 00000888 0
W 1 340 12345678 1
R 340 0 ffffffff 0
R 340 1 00000000 0
R 7c0 0 00000000 0
P 3 0 0 0
# Exception entry from machine mode
W 2 300 00000008 0
E 2 80000100 deadbeef 0
R 341 0 80000100 0
R 342 0 00000002 0
R 343 0 deadbeef 0
R 300 0 00001880 0
P 3 0 0 0
E 3 80000204 00000013 0
R 343 0 80000204 0
R 342 0 00000003 0
R 300 0 00001800 0
# Return to user mode, then trap back
W 1 300 00000080 0
M 0 0 0 0
P 0 0 0 0
R 300 0 00000088 0
E 8 00000100 00000073 0
P 3 0 0 0
R 300 0 00000080 0
R 341 0 00000100 0
R 343 0 00000100 0
# Interrupts, external then software then timer
W 2 300 00000008 0
I 888 80000400 0 0
R 342 0 8000000b 0
R 341 0 80000404 0
R 300 0 00001880 0
W 2 300 00000008 0
I 088 80000500 1 80000800
R 342 0 80000003 0
R 341 0 80000800 0
W 2 300 00000008 0
I 080 80000600 0 0
R 342 0 80000007 0
R 341 0 80000604 0
# Counters
W 1 b00 00001000 0
N 3 0 0 0
R b00 0 00001003 0
R c00 0 00001004 0
W 1 b80 00000007 0
R c80 0 00000007 0
R b00 0 00001006 0
W 1 b02 00000200 0
N 2 0 1 0
N 3 1 0 0
R b02 0 00000200 0
N 3 0 0 0
R c02 0 00000204 0
R c82 0 00000000 0

/* tb.f */
design/csr_pkg.sv
design/csr_trap_ctrl.sv
design/csr_access.sv
design/csr_trap_regs.sv
design/csr_counters.sv
design/csr_irq.sv
design/csr_bank.sv
tb/csr_bank_tb.sv

/* Makefile */
TOP = csr_bank_tb

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

build:
	verilator --binary --timing -j 0 -f tb.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f tb.f --top-module csr_bank

clean:
	rm -rf obj_dir

.PHONY: all build lint clean

/* tb/csr_bank_tb.sv */
// Testbench for the CSR bank, driven by a stimulus and expected-value trace
`timescale 1ns/1ps

module csr_bank_tb;

    localparam int IRQ_TIMEOUT = 20;   // Cycles allowed for the pending flag

    logic                           clk;
    logic                           reset_n;
    logic                           read_enable_i, write_enable_i, killed_i, hold_i;
    csr_pkg::csr_op_e               operation_i;
    logic [csr_pkg::CSR_ADDR_W-1:0] address_i;
    logic [csr_pkg::XLEN-1:0]       data_i, pc_i, instruction_i, jump_target_i, irq_i;
    logic                           raise_exception_i, machine_return_i;
    logic                           jump_i, interrupt_ack_i;
    csr_pkg::exc_code_e             exception_code_i;
    logic [csr_pkg::XLEN-1:0]       data_o, mepc_o, mtvec_o;
    logic                           interrupt_pending_o;
    csr_pkg::privilege_e            privilege_o;

    int          fd, fields, steps_run;
    string       line;
    logic [7:0]  kind;                 // Step letter of the trace line
    logic [31:0] f0, f1, f2, f3;

    csr_bank csr_bank_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

////////////////////////////////////////////////////////////////////////////
// Checks
////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input logic [csr_pkg::XLEN-1:0] got,
                              input logic [csr_pkg::XLEN-1:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_priv(input csr_pkg::privilege_e got,
                              input csr_pkg::privilege_e exp, input string what);
        if (got !== exp) begin
            $display("** Error @ %0t: %s is %s, expected %s", $time, what,
                     got.name(), exp.name());
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

////////////////////////////////////////////////////////////////////////////
// Trace steps entered on a falling edge
////////////////////////////////////////////////////////////////////////////

    task automatic clear_strobes();
        read_enable_i     = 1'b0;
        write_enable_i    = 1'b0;
        killed_i          = 1'b0;
        hold_i            = 1'b0;
        raise_exception_i = 1'b0;
        machine_return_i  = 1'b0;
        interrupt_ack_i   = 1'b0;
        jump_i            = 1'b0;
    endtask

    task automatic wait_pending();
        int waited;
        waited = 0;
        while (!interrupt_pending_o && waited < IRQ_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!interrupt_pending_o) begin
            $display("Error: interrupt_pending_o stayed low for %0d cycles", IRQ_TIMEOUT);
            abort_run();
        end
    endtask

    task automatic run_step();
        clear_strobes();
        case (kind)
            "W": begin
                write_enable_i = 1'b1;
                operation_i    = csr_pkg::csr_op_e'(f0[1:0]);
                address_i      = f1[csr_pkg::CSR_ADDR_W-1:0];
                data_i         = f2;
                killed_i       = f3[0];
                @(negedge clk);
            end
            "R": begin
                read_enable_i = 1'b1;
                address_i     = f0[csr_pkg::CSR_ADDR_W-1:0];
                killed_i      = f1[0];
                #5;                                 // Read port is combinational
                check_word(data_o, f2, $sformatf("read of CSR %h", address_i));
                // Dedicated trap vector and return address outputs
                if (!killed_i && address_i == csr_pkg::MTVEC) begin
                    check_word(mtvec_o, f2, "mtvec_o");
                end
                if (!killed_i && address_i == csr_pkg::MEPC) begin
                    check_word(mepc_o, f2, "mepc_o");
                end
                @(negedge clk);
            end
            "E": begin
                raise_exception_i = 1'b1;
                exception_code_i  = csr_pkg::exc_code_e'(f0[4:0]);
                pc_i              = f1;
                instruction_i     = f2;
                @(negedge clk);
            end
            "M": begin
                machine_return_i = 1'b1;
                @(negedge clk);
            end
            "P": begin
                #5;
                check_priv(privilege_o, csr_pkg::privilege_e'(f0[1:0]), "privilege_o");
                @(negedge clk);
            end
            "N": begin
                killed_i = f1[0];
                hold_i   = f2[0];
                repeat (f0) @(negedge clk);
            end
            "I": begin
                irq_i = f0;
                wait_pending();
                interrupt_ack_i = 1'b1;
                pc_i            = f1;
                jump_i          = f2[0];
                jump_target_i   = f3;
                @(negedge clk);
                clear_strobes();
                irq_i = '0;
                #5;
                check_bit(interrupt_pending_o, 1'b0, "interrupt_pending_o after ack");
                @(negedge clk);
            end
            default: begin
                $display("Error: unknown step kind '%s' in the trace", kind);
                abort_run();
            end
        endcase
    endtask

    initial begin
        reset_n = 1'b0;
        clear_strobes();
        operation_i      = csr_pkg::CSR_WRITE;
        exception_code_i = csr_pkg::INSTRUCTION_ADDRESS_MISALIGNED;
        address_i        = '0;
        data_i           = '0;
        pc_i             = '0;
        instruction_i    = '0;
        jump_target_i    = '0;
        irq_i            = '0;
        steps_run        = 0;
        fd = $fopen("tb/csr_trace.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open tb/csr_trace.txt for reading");
            abort_run();
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;   // Blank or comment
            fields = $sscanf(line, "%s %h %h %h %h", kind, f0, f1, f2, f3);
            if (fields != 5) begin
                $display("Error: malformed trace line: %s", line);
                abort_run();
            end
            run_step();
            steps_run++;
        end
        $fclose(fd);
        if (steps_run > 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Error: the trace held no steps");
            abort_run();
        end
    end

endmodule

/* design/csr_bank.sv */
// Machine-mode CSR bank top level connecting control, access, storage and interrupt blocks
`timescale 1ns/1ps

module csr_bank (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           read_enable_i,
    input  logic                           write_enable_i,
    input  logic                           killed_i,
    input  logic                           hold_i,
    input  csr_pkg::csr_op_e               operation_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] address_i,
    input  logic [csr_pkg::XLEN-1:0]       data_i,
    input  logic                           raise_exception_i,
    input  logic                           machine_return_i,
    input  csr_pkg::exc_code_e             exception_code_i,
    input  logic [csr_pkg::XLEN-1:0]       pc_i,
    input  logic [csr_pkg::XLEN-1:0]       instruction_i,
    input  logic                           jump_i,
    input  logic [csr_pkg::XLEN-1:0]       jump_target_i,
    input  logic [csr_pkg::XLEN-1:0]       irq_i,
    input  logic                           interrupt_ack_i,
    output logic [csr_pkg::XLEN-1:0]       data_o,
    output logic                           interrupt_pending_o,
    output csr_pkg::privilege_e            privilege_o,
    output logic [csr_pkg::XLEN-1:0]       mepc_o,
    output logic [csr_pkg::XLEN-1:0]       mtvec_o
);

    logic                     take_exc, take_irq, csr_we, mie_en;
    logic [csr_pkg::XLEN-1:0] wr_data, mstatus, mie, mip, mscratch, mcause, mtval;
    logic [63:0]              mcycle, minstret;
    csr_pkg::csr_addr_e       wr_sel;
    csr_pkg::irq_code_e       irq_code;

    csr_trap_ctrl csr_trap_ctrl_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .write_enable_i    (write_enable_i),
        .killed_i          (killed_i),
        .raise_exception_i (raise_exception_i),
        .machine_return_i  (machine_return_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .wr_sel_mstatus_i  (wr_sel == csr_pkg::MSTATUS),
        .wr_data_i         (wr_data),
        .take_exc_o        (take_exc),
        .take_irq_o        (take_irq),
        .csr_we_o          (csr_we),
        .mstatus_o         (mstatus),
        .mie_en_o          (mie_en),
        .privilege_o       (privilege_o)
    );

    csr_access csr_access_i (
        .address_i     (address_i),
        .operation_i   (operation_i),
        .data_i        (data_i),
        .read_enable_i (read_enable_i),
        .killed_i      (killed_i),
        .mstatus_i     (mstatus),
        .mie_i         (mie),
        .mip_i         (mip),
        .mtvec_i       (mtvec_o),
        .mscratch_i    (mscratch),
        .mepc_i        (mepc_o),
        .mcause_i      (mcause),
        .mtval_i       (mtval),
        .mcycle_i      (mcycle),
        .minstret_i    (minstret),
        .wr_data_o     (wr_data),
        .wr_sel_o      (wr_sel),
        .data_o        (data_o)
    );

    csr_trap_regs csr_trap_regs_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .take_exc_i       (take_exc),
        .take_irq_i       (take_irq),
        .csr_we_i         (csr_we),
        .wr_sel_i         (wr_sel),
        .wr_data_i        (wr_data),
        .exception_code_i (exception_code_i),
        .irq_code_i       (irq_code),
        .pc_i             (pc_i),
        .instruction_i    (instruction_i),
        .jump_i           (jump_i),
        .jump_target_i    (jump_target_i),
        .mie_o            (mie),
        .mtvec_o          (mtvec_o),
        .mscratch_o       (mscratch),
        .mepc_o           (mepc_o),
        .mcause_o         (mcause),
        .mtval_o          (mtval)
    );

    csr_counters csr_counters_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .killed_i   (killed_i),
        .hold_i     (hold_i),
        .csr_we_i   (csr_we),
        .wr_sel_i   (wr_sel),
        .wr_data_i  (wr_data),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    csr_irq csr_irq_i (
        .clk                 (clk),
        .reset_n             (reset_n),
        .irq_i               (irq_i),
        .mie_i               (mie),
        .mie_en_i            (mie_en),
        .interrupt_ack_i     (interrupt_ack_i),
        .mip_o               (mip),
        .interrupt_pending_o (interrupt_pending_o),
        .irq_code_o          (irq_code)
    );

endmodule

/* design/csr_irq.sv */
// Interrupt line sampling into mip, pending detection and cause priority encoding
`timescale 1ns/1ps

module csr_irq (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic [csr_pkg::XLEN-1:0] irq_i,
    input  logic [csr_pkg::XLEN-1:0] mie_i,
    input  logic                     mie_en_i,
    input  logic                     interrupt_ack_i,
    output logic [csr_pkg::XLEN-1:0] mip_o,
    output logic                     interrupt_pending_o,
    output csr_pkg::irq_code_e       irq_code_o
);

    logic [csr_pkg::XLEN-1:0] active;

    assign active = mie_i & mip_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_o <= '0;
        end else begin
            mip_o <= irq_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            interrupt_pending_o <= 1'b0;
            irq_code_o          <= csr_pkg::M_SW_INT;
        end else if (mie_en_i && active != '0 && !interrupt_ack_i) begin
            interrupt_pending_o <= 1'b1;
            if (active[csr_pkg::MEI_BIT]) begin         // External first
                irq_code_o <= csr_pkg::M_EXT_INT;
            end else if (active[csr_pkg::MSI_BIT]) begin
                irq_code_o <= csr_pkg::M_SW_INT;
            end else if (active[csr_pkg::MTI_BIT]) begin
                irq_code_o <= csr_pkg::M_TIM_INT;
            end
        end else begin
            interrupt_pending_o <= 1'b0;                // Dropped while acknowledging
        end
    end

endmodule

/* design/csr_counters.sv */
// 64-bit mcycle and minstret counters with per-half CSR writes
`timescale 1ns/1ps

module csr_counters (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     killed_i,
    input  logic                     hold_i,
    input  logic                     csr_we_i,
    input  csr_pkg::csr_addr_e       wr_sel_i,
    input  logic [csr_pkg::XLEN-1:0] wr_data_i,
    output logic [63:0]              mcycle_o,
    output logic [63:0]              minstret_o
);

    logic retire;

    assign retire = !killed_i && !hold_i;

    // Free running, a write loads instead of counting
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_o <= '0;
        end else if (csr_we_i && wr_sel_i == csr_pkg::MCYCLE) begin
            mcycle_o[31:0] <= wr_data_i;
        end else if (csr_we_i && wr_sel_i == csr_pkg::MCYCLEH) begin
            mcycle_o[63:32] <= wr_data_i;
        end else begin
            mcycle_o <= mcycle_o + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            minstret_o <= '0;
        end else if (csr_we_i && wr_sel_i == csr_pkg::MINSTRET) begin
            minstret_o[31:0] <= wr_data_i;
        end else if (csr_we_i && wr_sel_i == csr_pkg::MINSTRETH) begin
            minstret_o[63:32] <= wr_data_i;
        end else if (retire) begin
            minstret_o <= minstret_o + 64'd1;   // Killed or held slots don't count
        end
    end

endmodule

/* design/csr_trap_regs.sv */
// Trap-related CSR storage: mie, mtvec, mscratch, mepc, mcause and mtval
`timescale 1ns/1ps

module csr_trap_regs (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     take_exc_i,
    input  logic                     take_irq_i,
    input  logic                     csr_we_i,
    input  csr_pkg::csr_addr_e       wr_sel_i,
    input  logic [csr_pkg::XLEN-1:0] wr_data_i,
    input  csr_pkg::exc_code_e       exception_code_i,
    input  csr_pkg::irq_code_e       irq_code_i,
    input  logic [csr_pkg::XLEN-1:0] pc_i,
    input  logic [csr_pkg::XLEN-1:0] instruction_i,
    input  logic                     jump_i,
    input  logic [csr_pkg::XLEN-1:0] jump_target_i,
    output logic [csr_pkg::XLEN-1:0] mie_o,
    output logic [csr_pkg::XLEN-1:0] mtvec_o,
    output logic [csr_pkg::XLEN-1:0] mscratch_o,
    output logic [csr_pkg::XLEN-1:0] mepc_o,
    output logic [csr_pkg::XLEN-1:0] mcause_o,
    output logic [csr_pkg::XLEN-1:0] mtval_o
);

    localparam int CAUSE_PAD = csr_pkg::XLEN - 6;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mie_o      <= '0;
            mtvec_o    <= '0;
            mscratch_o <= '0;
            mepc_o     <= '0;
            mcause_o   <= '0;
            mtval_o    <= '0;
        end else if (take_exc_i) begin
            mepc_o   <= pc_i;
            mcause_o <= {1'b0, {CAUSE_PAD{1'b0}}, exception_code_i};
            mtval_o  <= (exception_code_i == csr_pkg::ILLEGAL_INSTRUCTION) ? instruction_i
                                                                            : pc_i;
        end else if (take_irq_i) begin
            mcause_o <= {1'b1, {CAUSE_PAD{1'b0}}, irq_code_i};
            // Current instruction retires, so return to the next one
            mepc_o   <= jump_i ? jump_target_i : pc_i + csr_pkg::PC_STEP;
        end else if (csr_we_i) begin
            case (wr_sel_i)
                csr_pkg::MIE:      mie_o      <= wr_data_i;
                csr_pkg::MTVEC:    mtvec_o    <= wr_data_i;
                csr_pkg::MSCRATCH: mscratch_o <= wr_data_i;
                csr_pkg::MEPC:     mepc_o     <= wr_data_i;
                csr_pkg::MCAUSE:   mcause_o   <= wr_data_i;
                csr_pkg::MTVAL:    mtval_o    <= wr_data_i;
                default: ;
            endcase
        end
    end

endmodule

/* design/csr_access.sv */
// Address decode, masked write data for write/set/clear, and the CSR read port
`timescale 1ns/1ps

module csr_access (
    input  logic [csr_pkg::CSR_ADDR_W-1:0] address_i,
    input  csr_pkg::csr_op_e               operation_i,
    input  logic [csr_pkg::XLEN-1:0]       data_i,
    input  logic                           read_enable_i,
    input  logic                           killed_i,
    input  logic [csr_pkg::XLEN-1:0]       mstatus_i,
    input  logic [csr_pkg::XLEN-1:0]       mie_i,
    input  logic [csr_pkg::XLEN-1:0]       mip_i,
    input  logic [csr_pkg::XLEN-1:0]       mtvec_i,
    input  logic [csr_pkg::XLEN-1:0]       mscratch_i,
    input  logic [csr_pkg::XLEN-1:0]       mepc_i,
    input  logic [csr_pkg::XLEN-1:0]       mcause_i,
    input  logic [csr_pkg::XLEN-1:0]       mtval_i,
    input  logic [63:0]                    mcycle_i,
    input  logic [63:0]                    minstret_i,
    output logic [csr_pkg::XLEN-1:0]       wr_data_o,
    output csr_pkg::csr_addr_e             wr_sel_o,
    output logic [csr_pkg::XLEN-1:0]       data_o
);

    csr_pkg::csr_addr_e       addr;
    logic [csr_pkg::XLEN-1:0] current_val, wmask, masked_data;

    assign addr     = csr_pkg::csr_addr_e'(address_i);
    assign wr_sel_o = addr;

    // Current value and writable bits of the addressed register
    always_comb begin
        current_val = '0;
        wmask       = '0;                      // Unmapped and read-only
        case (addr)
            csr_pkg::MSTATUS:   begin current_val = mstatus_i;         wmask = csr_pkg::MSTATUS_WMASK; end
            csr_pkg::MIE:       begin current_val = mie_i;             wmask = csr_pkg::MIE_WMASK;     end
            csr_pkg::MTVEC:     begin current_val = mtvec_i;           wmask = csr_pkg::ALIGN_WMASK;   end
            csr_pkg::MSCRATCH:  begin current_val = mscratch_i;        wmask = csr_pkg::FULL_WMASK;    end
            csr_pkg::MEPC:      begin current_val = mepc_i;            wmask = csr_pkg::ALIGN_WMASK;   end
            csr_pkg::MCAUSE:    begin current_val = mcause_i;          wmask = csr_pkg::FULL_WMASK;    end
            csr_pkg::MTVAL:     begin current_val = mtval_i;           wmask = csr_pkg::FULL_WMASK;    end
            csr_pkg::MCYCLE:    begin current_val = mcycle_i[31:0];    wmask = csr_pkg::FULL_WMASK;    end
            csr_pkg::MCYCLEH:   begin current_val = mcycle_i[63:32];   wmask = csr_pkg::FULL_WMASK;    end
            csr_pkg::MINSTRET:  begin current_val = minstret_i[31:0];  wmask = csr_pkg::FULL_WMASK;    end
            csr_pkg::MINSTRETH: begin current_val = minstret_i[63:32]; wmask = csr_pkg::FULL_WMASK;    end
            default: ;
        endcase
    end

    assign masked_data = data_i & wmask;

    always_comb begin
        case (operation_i)
            csr_pkg::CSR_SET:   wr_data_o = current_val | masked_data;
            csr_pkg::CSR_CLEAR: wr_data_o = current_val & ~masked_data;
            default:            wr_data_o = (current_val & ~wmask) | masked_data;
        endcase
    end

////////////////////////////////////////////////////////////////////////////
// Read port
////////////////////////////////////////////////////////////////////////////

    always_comb begin
        data_o = '0;
        if (read_enable_i && !killed_i) begin
            case (addr)
                csr_pkg::MSTATUS:                    data_o = mstatus_i;
                csr_pkg::MISA:                       data_o = csr_pkg::MISA_VALUE;
                csr_pkg::MIE:                        data_o = mie_i;
                csr_pkg::MIP:                        data_o = mip_i;
                csr_pkg::MTVEC:                      data_o = mtvec_i;
                csr_pkg::MSCRATCH:                   data_o = mscratch_i;
                csr_pkg::MEPC:                       data_o = mepc_i;
                csr_pkg::MCAUSE:                     data_o = mcause_i;
                csr_pkg::MTVAL:                      data_o = mtval_i;
                csr_pkg::MCYCLE, csr_pkg::CYCLE:     data_o = mcycle_i[31:0];
                csr_pkg::MCYCLEH, csr_pkg::CYCLEH:   data_o = mcycle_i[63:32];
                csr_pkg::MINSTRET, csr_pkg::INSTRET: data_o = minstret_i[31:0];
                csr_pkg::MINSTRETH,
                csr_pkg::INSTRETH:                   data_o = minstret_i[63:32];
                default:                             data_o = '0;   // IDs included
            endcase
        end
    end

endmodule

/* design/csr_trap_ctrl.sv */
// Event priority, action strobes, mstatus fields and current privilege level
`timescale 1ns/1ps

module csr_trap_ctrl (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     write_enable_i,
    input  logic                     killed_i,
    input  logic                     raise_exception_i,
    input  logic                     machine_return_i,
    input  logic                     interrupt_ack_i,
    input  logic                     wr_sel_mstatus_i,
    input  logic [csr_pkg::XLEN-1:0] wr_data_i,
    output logic                     take_exc_o,
    output logic                     take_irq_o,
    output logic                     csr_we_o,
    output logic [csr_pkg::XLEN-1:0] mstatus_o,
    output logic                     mie_en_o,
    output csr_pkg::privilege_e      privilege_o
);

    logic                mstatus_mie;
    logic                mstatus_mpie;
    csr_pkg::privilege_e mstatus_mpp;
    csr_pkg::privilege_e privilege;
    logic                take_exc, take_irq, csr_we;
    logic [1:0]          mpp_wr;

////////////////////////////////////////////////////////////////////////////
// Priority: return, exception, interrupt, CSR write
////////////////////////////////////////////////////////////////////////////

    assign take_exc = raise_exception_i && !machine_return_i;
    assign take_irq = interrupt_ack_i && !machine_return_i && !raise_exception_i;
    assign csr_we   = write_enable_i && !killed_i && !machine_return_i
                      && !raise_exception_i && !interrupt_ack_i;

    assign take_exc_o = take_exc;
    assign take_irq_o = take_irq;
    assign csr_we_o   = csr_we;

    assign mpp_wr = wr_data_i[csr_pkg::MPP_LSB +: 2];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= csr_pkg::PRIV_USER;
            privilege    <= csr_pkg::PRIV_MACHINE;
        end else if (machine_return_i) begin
            mstatus_mie <= mstatus_mpie;
            privilege   <= mstatus_mpp;
        end else if (take_exc || take_irq) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;              // Traps run with interrupts off
            mstatus_mpp  <= privilege;
            privilege    <= csr_pkg::PRIV_MACHINE;
        end else if (csr_we && wr_sel_mstatus_i) begin
            mstatus_mie  <= wr_data_i[csr_pkg::MIE_BIT];
            mstatus_mpie <= wr_data_i[csr_pkg::MPIE_BIT];
            // Only U and M exist, anything but U maps to M
            mstatus_mpp  <= (mpp_wr == csr_pkg::PRIV_USER) ? csr_pkg::PRIV_USER
                                                           : csr_pkg::PRIV_MACHINE;
        end
    end

    // Read view, unimplemented fields stay zero
    always_comb begin
        mstatus_o                              = '0;
        mstatus_o[csr_pkg::MIE_BIT]            = mstatus_mie;
        mstatus_o[csr_pkg::MPIE_BIT]           = mstatus_mpie;
        mstatus_o[csr_pkg::MPP_LSB +: 2]       = mstatus_mpp;
    end

    assign mie_en_o    = mstatus_mie;
    assign privilege_o = privilege;

endmodule

/* design/csr_pkg.sv */
// CSR widths, address map, opcode and cause enums, write masks and constants
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

////////////////////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////////////////////

    typedef enum logic [CSR_ADDR_W-1:0] {
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00,   // User read aliases
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82,
        MVENDORID  = 12'hF11,   // Identification, all read as zero
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15
    } csr_addr_e;

    // Matches funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } privilege_e;

    typedef enum logic [4:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 5'd0,
        ILLEGAL_INSTRUCTION            = 5'd2,
        BREAKPOINT                     = 5'd3,
        LOAD_ADDRESS_MISALIGNED        = 5'd4,
        STORE_ADDRESS_MISALIGNED       = 5'd6,
        ECALL_FROM_UMODE               = 5'd8,
        ECALL_FROM_MMODE               = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

////////////////////////////////////////////////////////////////////////////
// Constants and masks
////////////////////////////////////////////////////////////////////////////

    // MXL = 1, plus the U, M and I letters
    localparam logic [XLEN-1:0] MISA_VALUE    = 32'h4010_1100;

    localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_1888;
    localparam logic [XLEN-1:0] MIE_WMASK     = 32'h0000_0888;
    localparam logic [XLEN-1:0] ALIGN_WMASK   = 32'hFFFF_FFFC;
    localparam logic [XLEN-1:0] FULL_WMASK    = 32'hFFFF_FFFF;

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LSB  = 11;

    localparam int MSI_BIT  = 3;
    localparam int MTI_BIT  = 7;
    localparam int MEI_BIT  = 11;

    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

endpackage
